// ==== spec_pkg.sv ====
//##########################################################################
// frame size, field widths and stream structs for the spectrum path
// POWER_W must equal 2*SAMPLE_W and MAG_W must equal POWER_W/2
//##########################################################################
package spec_pkg;

   localparam int FFT_POINTS = 256;
   localparam int BIN_W      = 8;
   localparam int SAMPLE_W   = 10;
   localparam int EXP_W      = 6;
   localparam int POWER_W    = 20;
   localparam int MAG_W      = 10;
   localparam int CREDIT_MAX = 4;
   localparam int SHIFT_MAX  = 9;
   localparam int SHIFT_W    = $clog2(SHIFT_MAX + 1);
   localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);
   localparam int ROOT_CNT_W = $clog2(MAG_W);

   typedef struct packed {
      logic                       valid;
      logic                       sop;
      logic                       eop;
      logic signed [EXP_W-1:0]    exp;    // block exponent from the FFT core
      logic signed [SAMPLE_W-1:0] re;
      logic signed [SAMPLE_W-1:0] im;
   } fft_src_t;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] re;
      logic signed [SAMPLE_W-1:0] im;
   } bin_data_t;

   typedef struct packed {
      logic                       valid;
      logic                       last;
      logic [BIN_W-1:0]           idx;
      logic signed [SAMPLE_W-1:0] re;
      logic signed [SAMPLE_W-1:0] im;
   } bin_sample_t;

   typedef struct packed {
      logic             req;
      logic             we;
      logic [BIN_W-1:0] addr;
      bin_data_t        data;
   } mem_req_t;

   typedef struct packed {
      logic               valid;
      logic [BIN_W-1:0]   idx;
      logic [POWER_W-1:0] power;
      logic [MAG_W-1:0]   mag;      // floor sqrt of power
   } peak_rpt_t;

   typedef struct packed {
      logic               valid;
      logic               last;
      logic [BIN_W-1:0]   idx;
      logic [POWER_W-1:0] power;
   } spec_out_t;

   // re^2 + im^2, never exceeds 2^19 so it fits unsigned
   function automatic logic [POWER_W-1:0] bin_power(input logic signed [SAMPLE_W-1:0] re,
                                                    input logic signed [SAMPLE_W-1:0] im);
      logic signed [2*SAMPLE_W-1:0] re_sq;
      logic signed [2*SAMPLE_W-1:0] im_sq;
      re_sq = re * re;
      im_sq = im * im;
      return $unsigned(re_sq) + $unsigned(im_sq);
   endfunction

endpackage

// ==== bin_capture.sv ====
//##########################################################################
// no back-pressure on the input, every valid bin is taken
// positive exponents pass unscaled, negative shifts are capped at SHIFT_MAX
//##########################################################################
`timescale 1ns/1ps

module bin_capture
   import spec_pkg::*;
(
   input  logic        sys_clk,
   input  logic        sys_rst,
   input  fft_src_t    fft_src,
   output bin_sample_t sample,
   output mem_req_t    wr_req,
   output logic        frame_done
);

   logic [BIN_W-1:0]           bin_cnt;
   logic [BIN_W-1:0]           bin_idx;
   logic [EXP_W:0]             exp_mag;
   logic [SHIFT_W-1:0]         shamt;
   logic signed [SAMPLE_W-1:0] re_s;
   logic signed [SAMPLE_W-1:0] im_s;

   always_comb
   begin
      exp_mag = -{fft_src.exp[EXP_W-1], fft_src.exp};   // magnitude if exp < 0
      if (!fft_src.exp[EXP_W-1])
         shamt = '0;                                     // zero or positive exponent
      else if (int'(exp_mag) > SHIFT_MAX)
         shamt = SHIFT_W'(SHIFT_MAX);
      else
         shamt = SHIFT_W'(exp_mag);
      re_s    = $signed(fft_src.re) >>> shamt;
      im_s    = $signed(fft_src.im) >>> shamt;
      bin_idx = fft_src.sop ? '0 : bin_cnt;              // sop restarts numbering
   end

   always_ff @(posedge sys_clk or negedge sys_rst)
   begin
      if (!sys_rst)
      begin
         bin_cnt    <= '0;
         sample     <= '0;
         wr_req     <= '0;
         frame_done <= 1'b0;
      end
      else
      begin
         if (fft_src.valid)
            bin_cnt <= bin_idx + 1'b1;
         sample.valid <= fft_src.valid;
         sample.last  <= fft_src.valid & fft_src.eop;
         sample.idx   <= bin_idx;
         sample.re    <= re_s;
         sample.im    <= im_s;
         wr_req.req     <= fft_src.valid;                // one write per bin
         wr_req.we      <= 1'b1;
         wr_req.addr    <= bin_idx;
         wr_req.data.re <= re_s;
         wr_req.data.im <= im_s;
         frame_done <= sample.valid & sample.last;       // last write lands this edge
      end
   end

endmodule

// ==== isqrt.sv ====
//##########################################################################
// floor square root, one root bit per cycle, MAG_W cycles per result
//##########################################################################
`timescale 1ns/1ps

module isqrt
   import spec_pkg::*;
(
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               start,
   input  logic [POWER_W-1:0] radicand,
   output logic [MAG_W-1:0]   root,
   output logic               done
);

   logic [POWER_W-1:0]    rad_q;     // radicand bits not yet consumed
   logic [MAG_W+2:0]      rem_q;
   logic [MAG_W+2:0]      rem_shift;
   logic [MAG_W+2:0]      trial;
   logic [ROOT_CNT_W-1:0] step_q;
   logic                  busy_q;

   assign rem_shift = {rem_q[MAG_W:0], rad_q[POWER_W-1 -: 2]};   // bring down two bits
   assign trial     = {1'b0, root, 2'b01};                       // 4*root + 1

   always_ff @(posedge sys_clk or negedge sys_rst)
   begin
      if (!sys_rst)
      begin
         rad_q  <= '0;
         rem_q  <= '0;
         root   <= '0;
         step_q <= '0;
         busy_q <= 1'b0;
         done   <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (start)
         begin
            rad_q  <= radicand;
            rem_q  <= '0;
            root   <= '0;
            step_q <= ROOT_CNT_W'(MAG_W - 1);
            busy_q <= 1'b1;
         end
         else if (busy_q)
         begin
            rad_q <= rad_q << 2;
            if (rem_shift >= trial)
            begin
               rem_q <= rem_shift - trial;
               root  <= {root[MAG_W-2:0], 1'b1};
            end
            else
            begin
               rem_q <= rem_shift;
               root  <= {root[MAG_W-2:0], 1'b0};
            end
            step_q <= step_q - 1'b1;
            if (step_q == '0)
            begin
               busy_q <= 1'b0;
               done   <= 1'b1;          // root is final with this pulse
            end
         end
      end
   end

endmodule

// ==== peak_search.sv ====
//##########################################################################
// searches bins 1..FFT_POINTS/2 only, DC and upper half are ignored
// ties keep the lower index, report arrives after the square root finishes
//##########################################################################
`timescale 1ns/1ps

module peak_search
   import spec_pkg::*;
(
   input  logic        sys_clk,
   input  logic        sys_rst,
   input  bin_sample_t sample,
   output peak_rpt_t   peak
);

   logic [POWER_W-1:0] pwr;
   logic               in_half;
   logic               sqrt_start;
   logic               sqrt_done;
   logic [MAG_W-1:0]   sqrt_root;
   logic [POWER_W-1:0] max_pwr;
   logic [BIN_W-1:0]   max_idx;
   logic [POWER_W-1:0] hold_pwr;
   logic [BIN_W-1:0]   hold_idx;

   assign pwr        = bin_power(sample.re, sample.im);
   assign in_half    = sample.valid && (sample.idx != '0) && (int'(sample.idx) <= FFT_POINTS / 2);
   assign sqrt_start = sample.valid & sample.last;

   always_ff @(posedge sys_clk or negedge sys_rst)
   begin
      if (!sys_rst)
      begin
         max_pwr  <= '0;
         max_idx  <= '0;
         hold_pwr <= '0;
         hold_idx <= '0;
         peak     <= '0;
      end
      else
      begin
         // bin 1 seeds the running maximum, later bins need strictly more
         if (in_half && ((sample.idx == BIN_W'(1)) || (pwr > max_pwr)))
         begin
            max_pwr <= pwr;
            max_idx <= sample.idx;
         end
         if (sqrt_start)
         begin
            hold_pwr <= max_pwr;                // winner frozen while root runs
            hold_idx <= max_idx;
         end
         peak.valid <= sqrt_done;
         if (sqrt_done)
         begin
            peak.idx   <= hold_idx;
            peak.power <= hold_pwr;
            peak.mag   <= sqrt_root;
         end
      end
   end

   isqrt u_isqrt (
      .sys_clk  (sys_clk),
      .sys_rst  (sys_rst),
      .start    (sqrt_start),
      .radicand (max_pwr),
      .root     (sqrt_root),
      .done     (sqrt_done)
   );

endmodule

// ==== bin_mem.sv ====
//##########################################################################
// single-port bin memory, contents undefined until written
//##########################################################################
`timescale 1ns/1ps

module bin_mem
   import spec_pkg::*;
(
   input  logic      sys_clk,
   input  mem_req_t  req,
   output bin_data_t rd_data
);

   bin_data_t mem [FFT_POINTS];

   always_ff @(posedge sys_clk)
   begin
      if (req.req)
      begin
         if (req.we)
            mem[req.addr] <= req.data;
         else
            rd_data <= mem[req.addr];   // registered read
      end
   end

endmodule

// ==== mem_arbiter.sv ====
//##########################################################################
// writes always win, a read that meets a write is dropped
// the frame limit keeps readback sweeps clear of capture writes
//##########################################################################
`timescale 1ns/1ps

module mem_arbiter
   import spec_pkg::*;
(
   input  logic      sys_clk,
   input  logic      sys_rst,
   input  mem_req_t  wr_req,
   input  mem_req_t  rd_req,
   output logic      rd_valid,
   output bin_data_t rd_data
);

   mem_req_t mem_req;
   logic     rd_grant;

   assign rd_grant = rd_req.req & ~wr_req.req;
   assign mem_req  = wr_req.req ? wr_req : rd_req;

   always_ff @(posedge sys_clk or negedge sys_rst)
   begin
      if (!sys_rst)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_grant;            // data comes out of bin_mem one edge later
   end

   bin_mem u_bin_mem (
      .sys_clk (sys_clk),
      .req     (mem_req),
      .rd_data (rd_data)
   );

endmodule

// ==== spectrum_reader.sv ====
//##########################################################################
// one sweep per frame_done, a new frame must wait for the sweep to end
// credit_ret must pulse once per consumed item, never beyond CREDIT_MAX
//##########################################################################
`timescale 1ns/1ps

module spectrum_reader
   import spec_pkg::*;
(
   input  logic      sys_clk,
   input  logic      sys_rst,
   input  logic      frame_done,
   input  logic      credit_ret,
   output mem_req_t  rd_req,
   input  logic      rd_valid,
   input  bin_data_t rd_data,
   output spec_out_t spec
);

   logic                active;
   logic [BIN_W-1:0]    addr_q;
   logic [CREDIT_W-1:0] credit_q;
   logic                issue;
   logic                at_last;
   logic [BIN_W-1:0]    idx_d1;    // index of the read in flight
   logic                last_d1;

   assign issue   = active && (credit_q != '0);
   assign at_last = (addr_q == BIN_W'(FFT_POINTS - 1));

   always_comb
   begin
      rd_req      = '0;
      rd_req.req  = issue;
      rd_req.addr = addr_q;
   end

   always_ff @(posedge sys_clk or negedge sys_rst)
   begin
      if (!sys_rst)
      begin
         active   <= 1'b0;
         addr_q   <= '0;
         credit_q <= CREDIT_W'(CREDIT_MAX);
         idx_d1   <= '0;
         last_d1  <= 1'b0;
         spec     <= '0;
      end
      else
      begin
         if (frame_done)
            active <= 1'b1;
         if (issue)
         begin
            addr_q  <= addr_q + 1'b1;     // wraps to 0 after the last bin
            idx_d1  <= addr_q;
            last_d1 <= at_last;
            if (at_last)
               active <= 1'b0;
         end
         case ({issue, credit_ret})
            2'b10:   credit_q <= credit_q - 1'b1;
            2'b01:   credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;    // spent and returned together
         endcase
         spec.valid <= rd_valid;
         spec.last  <= rd_valid & last_d1;
         spec.idx   <= idx_d1;
         spec.power <= bin_power(rd_data.re, rd_data.im);
      end
   end

endmodule

// ==== spectrum_analyzer.sv ====
//##########################################################################
// spectrum post-processing for 256-bin FFT frames
// frames may only start once the previous readback sweep has finished
//##########################################################################
`timescale 1ns/1ps

module spectrum_analyzer
   import spec_pkg::*;
(
   input  logic      sys_clk,
   input  logic      sys_rst,
   input  fft_src_t  fft_src,
   output peak_rpt_t peak,
   output spec_out_t spec,
   input  logic      credit_ret
);

   bin_sample_t sample;
   mem_req_t    wr_req;
   mem_req_t    rd_req;
   logic        frame_done;
   logic        rd_valid;
   bin_data_t   rd_data;

   bin_capture u_capture (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .fft_src    (fft_src),
      .sample     (sample),
      .wr_req     (wr_req),
      .frame_done (frame_done)
   );

   peak_search u_peak (
      .sys_clk (sys_clk),
      .sys_rst (sys_rst),
      .sample  (sample),
      .peak    (peak)
   );

   mem_arbiter u_arbiter (
      .sys_clk  (sys_clk),
      .sys_rst  (sys_rst),
      .wr_req   (wr_req),
      .rd_req   (rd_req),
      .rd_valid (rd_valid),
      .rd_data  (rd_data)
   );

   spectrum_reader u_reader (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .frame_done (frame_done),
      .credit_ret (credit_ret),
      .rd_req     (rd_req),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .spec       (spec)
   );

endmodule

// ==== spectrum_analyzer_chk.sv ====
//##########################################################################
// bound into spectrum_reader, checks credits and the readback pipeline
//##########################################################################
`timescale 1ns/1ps

module spectrum_analyzer_chk
   import spec_pkg::*;
(
   input logic                sys_clk,
   input logic                sys_rst,
   input logic [CREDIT_W-1:0] credit_q,
   input logic                issue,
   input logic                rd_valid,
   input spec_out_t           spec
);

   credit_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst)
      credit_q <= CREDIT_W'(CREDIT_MAX))
      else $error("credit count above CREDIT_MAX");

   // nothing reaches the memory in a cycle with no credit
   no_read_without_credit: assert property (@(posedge sys_clk) disable iff (!sys_rst)
      (credit_q == '0) |=> !rd_valid)
      else $error("read issued with no credit left");

   // spec item two cycles after its read issue, through arbiter and memory
   spec_after_read: assert property (@(posedge sys_clk) disable iff (!sys_rst)
      issue |-> ##2 spec.valid)
      else $error("spec.valid not two cycles after a read issue");

endmodule

bind spectrum_reader spectrum_analyzer_chk u_chk (
   .sys_clk  (sys_clk),
   .sys_rst  (sys_rst),
   .credit_q (credit_q),
   .issue    (issue),
   .rd_valid (rd_valid),
   .spec     (spec)
);

// ==== spectrum_analyzer_tb.sv ====
//##########################################################################
// inputs change 1 ns after the rising edge, outputs sampled on the falling edge
// every frame is fully read back before the next one starts
//##########################################################################
`timescale 1ns/1ps

module spectrum_analyzer_tb
   import spec_pkg::*;
();

   logic      sys_clk;
   logic      sys_rst;
   fft_src_t  fft_src;
   logic      credit_ret;
   peak_rpt_t peak;
   spec_out_t spec;

   int        seed = 32'h1c0b9bfa;
   int        re_arr [FFT_POINTS];
   int        im_arr [FFT_POINTS];
   int        model_pwr [FFT_POINTS];
   int        model_idx;
   int        model_peak;
   int        val_errs = 0;
   int        timeouts = 0;
   int        spec_idx_q [$];
   int        spec_pwr_q [$];
   bit        spec_last_q [$];
   int        peak_cnt = 0;
   peak_rpt_t peak_got;
   bit        credit_en = 1'b1;
   int        pending = 0;          // items seen but not yet credited back

   spectrum_analyzer dut0 (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .fft_src    (fft_src),
      .peak       (peak),
      .spec       (spec),
      .credit_ret (credit_ret)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever #10 sys_clk = ~sys_clk;
   end

   always @(negedge sys_clk)
   begin
      if (sys_rst && spec.valid)
      begin
         spec_idx_q.push_back(int'(spec.idx));
         spec_pwr_q.push_back(int'(spec.power));
         spec_last_q.push_back(spec.last);
         pending++;
      end
      if (sys_rst && peak.valid)
      begin
         peak_cnt++;
         peak_got = peak;
      end
   end

   // consumer, one credit back per item while enabled
   initial
   begin
      forever
      begin
         @(posedge sys_clk);
         #1;
         if (credit_en && pending > 0)
         begin
            credit_ret = 1'b1;
            pending--;
         end
         else
            credit_ret = 1'b0;
      end
   end

   task automatic check_value(input string test, input string what,
                              input int exp_v, input int got_v);
      assert (exp_v == got_v)
      else
      begin
         $display("FAILED %s %s: expected %0d, actual %0d", test, what, exp_v, got_v);
         val_errs++;
      end
   endtask

   task automatic fill_random(input int amp);
      for (int i = 0; i < FFT_POINTS; i++)
      begin
         re_arr[i] = $random(seed) % amp;    // stays inside -(amp-1)..amp-1
         im_arr[i] = $random(seed) % amp;
      end
   endtask

   function automatic int rescale(input int v, input int e);
      int sh;
      if (e >= 0)
         return v;
      sh = (-e > SHIFT_MAX) ? SHIFT_MAX : -e;
      return v >>> sh;
   endfunction

   function automatic int floor_sqrt(input int p);
      int r;
      r = 0;
      while ((r + 1) * (r + 1) <= p)
         r++;
      return r;
   endfunction

   task automatic build_model(input int e);
      int r;
      int m;
      for (int i = 0; i < FFT_POINTS; i++)
      begin
         r = rescale(re_arr[i], e);
         m = rescale(im_arr[i], e);
         model_pwr[i] = r * r + m * m;
      end
      model_idx  = 1;
      model_peak = model_pwr[1];
      for (int i = 2; i <= FFT_POINTS / 2; i++)
      begin
         if (model_pwr[i] > model_peak)      // strictly greater, lower index keeps ties
         begin
            model_idx  = i;
            model_peak = model_pwr[i];
         end
      end
   endtask

   task automatic send_frame(input int e);
      for (int i = 0; i < FFT_POINTS; i++)
      begin
         @(posedge sys_clk);
         #1;
         fft_src.valid = 1'b1;
         fft_src.sop   = (i == 0);
         fft_src.eop   = (i == FFT_POINTS - 1);
         fft_src.exp   = EXP_W'(e);
         fft_src.re    = SAMPLE_W'(re_arr[i]);
         fft_src.im    = SAMPLE_W'(im_arr[i]);
      end
      @(posedge sys_clk);
      #1;
      fft_src = '0;
   endtask

   task automatic clear_capture();
      spec_idx_q.delete();
      spec_pwr_q.delete();
      spec_last_q.delete();
      peak_cnt = 0;
   endtask

   task automatic wait_items(input string test, input int n);
      int cyc;
      cyc = 0;
      while (spec_idx_q.size() < n && cyc < 4000)
      begin
         @(posedge sys_clk);
         cyc++;
      end
      if (spec_idx_q.size() < n)
      begin
         $display("%s: timed out waiting for readback, got %0d of %0d items",
                  test, spec_idx_q.size(), n);
         timeouts++;
      end
   endtask

   task automatic wait_peak(input string test);
      int cyc;
      cyc = 0;
      while (peak_cnt == 0 && cyc < 400)
      begin
         @(posedge sys_clk);
         cyc++;
      end
      if (peak_cnt == 0)
      begin
         $display("%s: timed out waiting for the peak report", test);
         timeouts++;
      end
   endtask

   task automatic check_peak(input string test);
      check_value(test, "peak count", 1, peak_cnt);
      check_value(test, "peak idx", model_idx, int'(peak_got.idx));
      check_value(test, "peak power", model_peak, int'(peak_got.power));
      check_value(test, "peak mag", floor_sqrt(model_peak), int'(peak_got.mag));
   endtask

   task automatic check_readback(input string test);
      check_value(test, "item count", FFT_POINTS, spec_idx_q.size());
      for (int i = 0; i < spec_idx_q.size() && i < FFT_POINTS; i++)
      begin
         check_value(test, "item idx", i, spec_idx_q[i]);
         check_value(test, "item power", model_pwr[i], spec_pwr_q[i]);
         check_value(test, "item last", int'(i == FFT_POINTS - 1), int'(spec_last_q[i]));
      end
   endtask

   task automatic run_frame(input string test, input int e);
      clear_capture();
      build_model(e);
      send_frame(e);
      check_value(test, "items before frame end", 0, spec_idx_q.size());
      check_value(test, "peaks before frame end", 0, peak_cnt);
      wait_peak(test);
      wait_items(test, FFT_POINTS);
      check_peak(test);
      check_readback(test);
   endtask

   task automatic test_reset();
      repeat (16)
      begin
         @(negedge sys_clk);
         check_value("reset", "peak.valid in reset", 0, int'(peak.valid));
         check_value("reset", "spec.valid in reset", 0, int'(spec.valid));
      end
      @(posedge sys_clk);
      #1;
      sys_rst = 1'b1;
      repeat (8)
      begin
         @(negedge sys_clk);
         check_value("reset", "peak.valid idle", 0, int'(peak.valid));
         check_value("reset", "spec.valid idle", 0, int'(spec.valid));
      end
   endtask

   task automatic test_single_tone();
      fill_random(8);
      re_arr[37] = 300;
      im_arr[37] = -200;
      run_frame("single_tone", 2);      // positive exponent passes unscaled
   endtask

   task automatic test_exp_rescale();
      fill_random(64);
      re_arr[90] = -509;
      im_arr[90] = 301;
      run_frame("exp_rescale", -3);
      run_frame("exp_cap", -20);        // shift capped at SHIFT_MAX
   endtask

   task automatic test_excluded_bins();
      fill_random(16);
      re_arr[0]   = 511;                // DC, strongest overall
      im_arr[0]   = 511;
      re_arr[200] = -512;               // upper half
      im_arr[200] = 500;
      re_arr[20]  = 100;                // tie with bin 50
      im_arr[20]  = 0;
      re_arr[50]  = 0;
      im_arr[50]  = -100;
      run_frame("excluded_bins", 0);
   endtask

   task automatic test_credit();
      int cyc;
      cyc = 0;
      while (pending > 0 && cyc < 50)
      begin
         @(posedge sys_clk);
         cyc++;
      end
      if (pending > 0)
      begin
         $display("credit: earlier items were never credited back");
         timeouts++;
      end
      credit_en = 1'b0;
      clear_capture();
      fill_random(32);
      build_model(-1);
      send_frame(-1);
      wait_items("credit", CREDIT_MAX);
      repeat (50) @(posedge sys_clk);   // sweep must stay halted
      check_value("credit", "items while withheld", CREDIT_MAX, spec_idx_q.size());
      credit_en = 1'b1;
      wait_peak("credit");
      wait_items("credit", FFT_POINTS);
      check_peak("credit");
      check_readback("credit");
   endtask

   initial
   begin
      fft_src    = '0;
      credit_ret = 1'b0;
      sys_rst    = 1'b0;
      test_reset();
      test_single_tone();
      test_exp_rescale();
      test_excluded_bins();
      test_credit();
      repeat (5) @(posedge sys_clk);
      $display("value errors: %0d, timeouts: %0d", val_errs, timeouts);
      if (val_errs == 0 && timeouts == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== spectrum_analyzer.f ====
spec_pkg.sv
bin_capture.sv
isqrt.sv
peak_search.sv
bin_mem.sv
mem_arbiter.sv
spectrum_reader.sv
spectrum_analyzer.sv
spectrum_analyzer_chk.sv
spectrum_analyzer_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the spectrum analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module spectrum_analyzer_tb -f spectrum_analyzer.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vspectrum_analyzer_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
   exit 0
fi
exit 1
